// ==== src/cpu_core_params.svh ====
`ifndef CPU_CORE_PARAMS_SVH
`define CPU_CORE_PARAMS_SVH

// data and address width
`define CPU_XLEN 32

// general register count and index width
`define CPU_NUM_REGS 32
`define CPU_REG_ADDR_W 5

// first fetch address after reset
`define CPU_RESET_PC 32'h0000_0000

`endif

// ==== src/cpu_core_pkg.sv ====
`default_nettype none

`include "cpu_core_params.svh"

package cpu_core_pkg;

    // RV32I major opcodes handled by the core
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        XOR = 3'd2,
        OR  = 3'd3,
        AND = 3'd4,
        SLL = 3'd5,
        SRL = 3'd6
    } alu_op_e;

    typedef struct packed {
        opcode_e                     opcode;
        logic [`CPU_REG_ADDR_W-1:0]  rd;
        logic [`CPU_REG_ADDR_W-1:0]  rs1;
        logic [`CPU_REG_ADDR_W-1:0]  rs2;
        logic [`CPU_XLEN-1:0]        imm;       // already sign-extended
        alu_op_e                     alu_op;
        logic                        use_imm;
        logic                        reg_write;
        logic                        mem_read;
        logic                        mem_write;
        logic                        is_branch;
        logic                        branch_ne; // bne when set, else beq
        logic                        is_jal;
        logic                        illegal;
    } decoded_instr_t;

    typedef struct packed {
        logic [`CPU_XLEN-1:0] addr;
        logic                 write;
        logic [`CPU_XLEN-1:0] wdata;
    } bus_req_t;

    typedef struct packed {
        logic [`CPU_XLEN-1:0] rdata;
    } bus_rsp_t;

    // sequencer side request has the same fields as the bus request
    typedef bus_req_t mem_req_t;

endpackage

`default_nettype wire

// ==== src/instr_decoder.sv ====
`default_nettype none

`include "cpu_core_params.svh"

module instr_decoder (
    input  wire logic [`CPU_XLEN-1:0]       instr_i,
    output cpu_core_pkg::decoded_instr_t    dec_o
);

    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       bad_funct;  // supported opcode with an unsupported funct3
    cpu_core_pkg::alu_op_e arith_op;

    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    // funct3 to ALU op, shared by the register and immediate forms
    always_comb begin
        bad_funct = 1'b0;
        case (funct3)
            3'b000:  arith_op = cpu_core_pkg::ADD;
            3'b100:  arith_op = cpu_core_pkg::XOR;
            3'b110:  arith_op = cpu_core_pkg::OR;
            3'b111:  arith_op = cpu_core_pkg::AND;
            3'b001:  arith_op = cpu_core_pkg::SLL;
            3'b101:  arith_op = cpu_core_pkg::SRL;
            default: begin
                arith_op  = cpu_core_pkg::ADD;
                bad_funct = 1'b1;
            end
        endcase
    end

    always_comb begin
        dec_o        = '0;
        dec_o.opcode = cpu_core_pkg::opcode_e'(instr_i[6:0]);
        dec_o.rd     = instr_i[11:7];
        dec_o.rs1    = instr_i[19:15];
        dec_o.rs2    = instr_i[24:20];
        dec_o.alu_op = cpu_core_pkg::ADD;

        case (instr_i[6:0])
            cpu_core_pkg::OP: begin
                dec_o.alu_op    = (funct3 == 3'b000 && funct7[5]) ? cpu_core_pkg::SUB : arith_op;
                dec_o.reg_write = 1'b1;
                dec_o.illegal   = bad_funct;
            end
            cpu_core_pkg::OP_IMM: begin
                dec_o.imm       = {{(`CPU_XLEN-12){instr_i[31]}}, instr_i[31:20]};
                dec_o.alu_op    = arith_op;
                dec_o.use_imm   = 1'b1;
                dec_o.reg_write = 1'b1;
                dec_o.illegal   = bad_funct;
            end
            cpu_core_pkg::LOAD: begin  // lw only
                dec_o.imm       = {{(`CPU_XLEN-12){instr_i[31]}}, instr_i[31:20]};
                dec_o.use_imm   = 1'b1;
                dec_o.reg_write = 1'b1;
                dec_o.mem_read  = 1'b1;
                dec_o.illegal   = (funct3 != 3'b010);
            end
            cpu_core_pkg::STORE: begin // sw only
                dec_o.imm       = {{(`CPU_XLEN-12){instr_i[31]}}, funct7, instr_i[11:7]};
                dec_o.use_imm   = 1'b1;
                dec_o.mem_write = 1'b1;
                dec_o.illegal   = (funct3 != 3'b010);
            end
            cpu_core_pkg::BRANCH: begin
                dec_o.imm       = {{(`CPU_XLEN-13){instr_i[31]}}, instr_i[31], instr_i[7],
                                   instr_i[30:25], instr_i[11:8], 1'b0};
                dec_o.is_branch = 1'b1;
                dec_o.branch_ne = funct3[0];
                dec_o.illegal   = (funct3[2:1] != 2'b00);  // beq, bne
            end
            cpu_core_pkg::JAL: begin
                dec_o.imm       = {{(`CPU_XLEN-21){instr_i[31]}}, instr_i[31], instr_i[19:12],
                                   instr_i[20], instr_i[30:21], 1'b0};
                dec_o.is_jal    = 1'b1;
                dec_o.reg_write = 1'b1;
            end
            default: dec_o.illegal = 1'b1;
        endcase

        // illegal words become no-ops
        if (dec_o.illegal) begin
            dec_o.reg_write = 1'b0;
            dec_o.mem_read  = 1'b0;
            dec_o.mem_write = 1'b0;
            dec_o.is_branch = 1'b0;
            dec_o.is_jal    = 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== src/alu.sv ====
`default_nettype none

`include "cpu_core_params.svh"

module alu (
    input  cpu_core_pkg::decoded_instr_t dec_i,
    input  wire logic [`CPU_XLEN-1:0]    rs1_val_i,
    input  wire logic [`CPU_XLEN-1:0]    rs2_val_i,
    output logic [`CPU_XLEN-1:0]         result_o,
    output logic                         branch_taken_o
);

    logic [`CPU_XLEN-1:0] op_b;
    logic                 equal;

    assign op_b  = dec_i.use_imm ? dec_i.imm : rs2_val_i;
    assign equal = (rs1_val_i == rs2_val_i);  // branches compare registers

    // loads and stores decode as ADD with the immediate, so the address falls out here
    always_comb begin
        case (dec_i.alu_op)
            cpu_core_pkg::ADD: result_o = rs1_val_i + op_b;
            cpu_core_pkg::SUB: result_o = rs1_val_i - op_b;
            cpu_core_pkg::XOR: result_o = rs1_val_i ^ op_b;
            cpu_core_pkg::OR:  result_o = rs1_val_i | op_b;
            cpu_core_pkg::AND: result_o = rs1_val_i & op_b;
            cpu_core_pkg::SLL: result_o = rs1_val_i << op_b[4:0];
            cpu_core_pkg::SRL: result_o = rs1_val_i >> op_b[4:0];
            default:           result_o = rs1_val_i + op_b;
        endcase
    end

    always_comb begin
        branch_taken_o = 1'b0;
        if (dec_i.is_branch) begin
            branch_taken_o = dec_i.branch_ne ? !equal : equal;
        end
    end

endmodule

`default_nettype wire

// ==== src/register_file.sv ====
`default_nettype none

`include "cpu_core_params.svh"

module register_file (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire logic [`CPU_REG_ADDR_W-1:0] rs1_addr_i,
    input  wire logic [`CPU_REG_ADDR_W-1:0] rs2_addr_i,
    output logic [`CPU_XLEN-1:0]            rs1_val_o,
    output logic [`CPU_XLEN-1:0]            rs2_val_o,
    input  wire logic                       write_en_i,
    input  wire logic [`CPU_REG_ADDR_W-1:0] rd_addr_i,
    input  wire logic [`CPU_XLEN-1:0]       rd_val_i
);

    logic [`CPU_XLEN-1:0] regs [`CPU_NUM_REGS];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `CPU_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en_i && rd_addr_i != '0) begin  // x0 stays zero
            regs[rd_addr_i] <= rd_val_i;
        end
    end

    assign rs1_val_o = regs[rs1_addr_i];
    assign rs2_val_o = regs[rs2_addr_i];

endmodule

`default_nettype wire

// ==== src/mem_controller.sv ====
`default_nettype none

`include "cpu_core_params.svh"

module mem_controller (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    mem_req_valid_i,
    input  cpu_core_pkg::mem_req_t       mem_req_i,
    output logic                         mem_req_ready_o,
    output logic                         mem_done_o,
    output logic [`CPU_XLEN-1:0]         mem_rdata_o,
    output logic                         bus_req_valid_o,
    output cpu_core_pkg::bus_req_t       bus_req_o,
    input  wire logic                    bus_req_ready_i,
    input  wire logic                    bus_rsp_valid_i,
    input  cpu_core_pkg::bus_rsp_t       bus_rsp_i
);

    typedef enum logic [1:0] {
        IDLE,
        REQUEST,
        WAIT_RSP
    } state_t;

    state_t                 state_q;
    cpu_core_pkg::bus_req_t req_q;
    logic                   done_q;
    logic [`CPU_XLEN-1:0]   rdata_q;

    assign mem_req_ready_o = (state_q == IDLE);
    assign bus_req_valid_o = (state_q == REQUEST);
    assign bus_req_o       = req_q;    // held steady until accepted
    assign mem_done_o      = done_q;
    assign mem_rdata_o     = rdata_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= IDLE;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (mem_req_valid_i) begin
                        state_q <= REQUEST;
                    end
                end
                REQUEST: begin
                    if (bus_req_ready_i) begin
                        if (req_q.write) begin
                            state_q <= IDLE;
                            done_q  <= 1'b1;  // write needs no response
                        end else begin
                            state_q <= WAIT_RSP;
                        end
                    end
                end
                WAIT_RSP: begin
                    if (bus_rsp_valid_i) begin
                        state_q <= IDLE;
                        done_q  <= 1'b1;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // request and read data registers
    always_ff @(posedge clk) begin
        if (state_q == IDLE && mem_req_valid_i) begin
            req_q <= mem_req_i;
        end
        if (state_q == WAIT_RSP && bus_rsp_valid_i) begin
            rdata_q <= bus_rsp_i.rdata;
        end
    end

endmodule

`default_nettype wire

// ==== src/core_sequencer.sv ====
`default_nettype none

`include "cpu_core_params.svh"

module core_sequencer (
    input  wire logic                       clk,
    input  wire logic                       rst,
    output cpu_core_pkg::decoded_instr_t    dec_o,
    output logic [`CPU_XLEN-1:0]            instr_o,
    input  cpu_core_pkg::decoded_instr_t    dec_i,
    input  wire logic [`CPU_XLEN-1:0]       alu_result_i,
    input  wire logic                       branch_taken_i,
    input  wire logic [`CPU_XLEN-1:0]       rs2_val_i,
    output logic                            mem_req_valid_o,
    output cpu_core_pkg::mem_req_t          mem_req_o,
    input  wire logic                       mem_req_ready_i,
    input  wire logic                       mem_done_i,
    input  wire logic [`CPU_XLEN-1:0]       mem_rdata_i,
    output logic                            rf_write_en_o,
    output logic [`CPU_REG_ADDR_W-1:0]      rf_rd_addr_o,
    output logic [`CPU_XLEN-1:0]            rf_rd_val_o
);

    typedef enum logic [2:0] {
        FETCH,
        FETCH_WAIT,
        EXECUTE,
        MEM,
        MEM_WAIT
    } state_t;

    state_t               state_q;
    logic [`CPU_XLEN-1:0] pc_q;
    logic [`CPU_XLEN-1:0] ir_q;
    logic                 req_valid_q;
    logic [`CPU_XLEN-1:0] pc_plus4;
    logic [`CPU_XLEN-1:0] pc_next;
    logic                 mem_access;

    assign instr_o    = ir_q;
    assign dec_o      = dec_i;  // decoded ir fans out to ALU and register file
    assign pc_plus4   = pc_q + `CPU_XLEN'd4;
    assign pc_next    = (dec_i.is_jal || branch_taken_i) ? pc_q + dec_i.imm : pc_plus4;
    assign mem_access = dec_i.mem_read || dec_i.mem_write;

    assign mem_req_valid_o = req_valid_q;

    // fetch uses the pc, the data phase uses the ALU address
    always_comb begin
        mem_req_o      = '0;
        mem_req_o.addr = pc_q;
        if (state_q == MEM) begin
            mem_req_o.addr  = alu_result_i;
            mem_req_o.write = dec_i.mem_write;
            mem_req_o.wdata = rs2_val_i;
        end
    end

    // writeback choice
    assign rf_rd_addr_o  = dec_i.rd;
    assign rf_write_en_o = (state_q == EXECUTE && dec_i.reg_write && !dec_i.mem_read)
                        || (state_q == MEM_WAIT && mem_done_i && dec_i.mem_read);
    always_comb begin
        if (dec_i.mem_read) begin
            rf_rd_val_o = mem_rdata_i;
        end else if (dec_i.is_jal) begin
            rf_rd_val_o = pc_plus4;  // link value
        end else begin
            rf_rd_val_o = alu_result_i;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q     <= FETCH;
            pc_q        <= `CPU_RESET_PC;
            req_valid_q <= 1'b0;
        end else begin
            case (state_q)
                FETCH, MEM: begin
                    if (!req_valid_q) begin
                        req_valid_q <= 1'b1;
                    end else if (mem_req_ready_i) begin
                        req_valid_q <= 1'b0;
                        state_q     <= (state_q == FETCH) ? FETCH_WAIT : MEM_WAIT;
                    end
                end
                FETCH_WAIT: begin
                    if (mem_done_i) begin
                        state_q <= EXECUTE;
                    end
                end
                EXECUTE: begin
                    pc_q    <= pc_next;
                    state_q <= mem_access ? MEM : FETCH;
                end
                MEM_WAIT: begin
                    if (mem_done_i) begin
                        state_q <= FETCH;
                    end
                end
                default: state_q <= FETCH;
            endcase
        end
    end

    // instruction register
    always_ff @(posedge clk) begin
        if (state_q == FETCH_WAIT && mem_done_i) begin
            ir_q <= mem_rdata_i;
        end
    end

endmodule

`default_nettype wire

// ==== src/cpu_core.sv ====
`default_nettype none

`include "cpu_core_params.svh"

module cpu_core (
    input  wire logic               clk,
    input  wire logic               rst,
    output logic                    bus_req_valid_o,
    output cpu_core_pkg::bus_req_t  bus_req_o,
    input  wire logic               bus_req_ready_i,
    input  wire logic               bus_rsp_valid_i,
    input  cpu_core_pkg::bus_rsp_t  bus_rsp_i
);

    cpu_core_pkg::decoded_instr_t dec_raw;   // decoder output
    cpu_core_pkg::decoded_instr_t dec;       // as issued by the sequencer
    cpu_core_pkg::mem_req_t       mem_req;
    logic [`CPU_XLEN-1:0]         instr;
    logic [`CPU_XLEN-1:0]         rs1_val;
    logic [`CPU_XLEN-1:0]         rs2_val;
    logic [`CPU_XLEN-1:0]         alu_result;
    logic                         branch_taken;
    logic                         mem_req_valid;
    logic                         mem_req_ready;
    logic                         mem_done;
    logic [`CPU_XLEN-1:0]         mem_rdata;
    logic                         rf_write_en;
    logic [`CPU_REG_ADDR_W-1:0]   rf_rd_addr;
    logic [`CPU_XLEN-1:0]         rf_rd_val;

    instr_decoder u_decoder (
        .instr_i (instr),
        .dec_o   (dec_raw)
    );

    alu u_alu (
        .dec_i          (dec),
        .rs1_val_i      (rs1_val),
        .rs2_val_i      (rs2_val),
        .result_o       (alu_result),
        .branch_taken_o (branch_taken)
    );

    register_file u_regfile (
        .clk        (clk),
        .rst        (rst),
        .rs1_addr_i (dec.rs1),
        .rs2_addr_i (dec.rs2),
        .rs1_val_o  (rs1_val),
        .rs2_val_o  (rs2_val),
        .write_en_i (rf_write_en),
        .rd_addr_i  (rf_rd_addr),
        .rd_val_i   (rf_rd_val)
    );

    mem_controller u_mem_ctrl (
        .clk             (clk),
        .rst             (rst),
        .mem_req_valid_i (mem_req_valid),
        .mem_req_i       (mem_req),
        .mem_req_ready_o (mem_req_ready),
        .mem_done_o      (mem_done),
        .mem_rdata_o     (mem_rdata),
        .bus_req_valid_o (bus_req_valid_o),
        .bus_req_o       (bus_req_o),
        .bus_req_ready_i (bus_req_ready_i),
        .bus_rsp_valid_i (bus_rsp_valid_i),
        .bus_rsp_i       (bus_rsp_i)
    );

    core_sequencer u_sequencer (
        .clk             (clk),
        .rst             (rst),
        .dec_o           (dec),
        .instr_o         (instr),
        .dec_i           (dec_raw),
        .alu_result_i    (alu_result),
        .branch_taken_i  (branch_taken),
        .rs2_val_i       (rs2_val),
        .mem_req_valid_o (mem_req_valid),
        .mem_req_o       (mem_req),
        .mem_req_ready_i (mem_req_ready),
        .mem_done_i      (mem_done),
        .mem_rdata_i     (mem_rdata),
        .rf_write_en_o   (rf_write_en),
        .rf_rd_addr_o    (rf_rd_addr),
        .rf_rd_val_o     (rf_rd_val)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_memory_model.sv ====
`default_nettype none

`include "cpu_core_params.svh"

module tb_memory_model #(
    parameter int unsigned SEED = 32'h42a9
) (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              stall_en_i,  // random ready gaps and read delays
    input  wire logic              req_valid_i,
    input  cpu_core_pkg::bus_req_t req_i,
    output logic                   req_ready_o,
    output logic                   rsp_valid_o,
    output cpu_core_pkg::bus_rsp_t rsp_o
);

    logic [`CPU_XLEN-1:0] mem [1024];  // word array indexed by addr / 4

    logic                 pending;
    logic                 stall;
    int                   delay;
    logic [`CPU_XLEN-1:0] rdata;

    initial begin
        void'($urandom(SEED));
        req_ready_o = 1'b0;
        rsp_valid_o = 1'b0;
        rsp_o       = '0;
        pending     = 1'b0;
        delay       = 0;
        rdata       = '0;
        forever begin
            @(posedge clk);
            // bus as it stood just before the edge
            stall = stall_en_i;
            if (rst) begin
                pending = 1'b0;
            end else if (req_valid_i && req_ready_o) begin
                if (req_i.write) begin
                    mem[req_i.addr[11:2]] = req_i.wdata;
                end else begin
                    pending = 1'b1;
                    rdata   = mem[req_i.addr[11:2]];
                    delay   = stall ? int'($urandom % 4) : 0;
                end
            end

            #1;
            rsp_valid_o = 1'b0;
            if (pending && delay == 0) begin
                rsp_valid_o = 1'b1;  // single cycle pulse
                rsp_o.rdata = rdata;
                pending     = 1'b0;
            end else if (pending) begin
                delay--;
            end
            req_ready_o = stall ? ($urandom % 3 != 0) : 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== testbench/tb_cpu_core.sv ====
`default_nettype none

`include "cpu_core_params.svh"

module tb_cpu_core;

    localparam logic [`CPU_XLEN-1:0] RESULT_BASE = 32'h100;
    localparam logic [6:0]            OPC_IMM     = 7'b0010011;
    localparam logic [6:0]            OPC_LOAD    = 7'b0000011;
    localparam int                    WAIT_LIMIT  = 4000;  // cycles

    logic                   clk;
    logic                   rst;
    logic                   stall_en;
    logic                   bus_req_valid;
    cpu_core_pkg::bus_req_t bus_req;
    logic                   bus_req_ready;
    logic                   bus_rsp_valid;
    cpu_core_pkg::bus_rsp_t bus_rsp;

    int                     errors;
    int                     tests_run;
    int                     tests_failed;
    int                     hold_count;
    string                  cur_test;
    logic [31:0]            prog [$];
    cpu_core_pkg::bus_req_t stores [$];   // accepted writes to the result area
    cpu_core_pkg::bus_req_t held_req;
    logic                   held;

    cpu_core DUT (
        .clk             (clk),
        .rst             (rst),
        .bus_req_valid_o (bus_req_valid),
        .bus_req_o       (bus_req),
        .bus_req_ready_i (bus_req_ready),
        .bus_rsp_valid_i (bus_rsp_valid),
        .bus_rsp_i       (bus_rsp)
    );

    tb_memory_model #(.SEED(32'h42a9)) mem_model (
        .clk         (clk),
        .rst         (rst),
        .stall_en_i  (stall_en),
        .req_valid_i (bus_req_valid),
        .req_i       (bus_req),
        .req_ready_o (bus_req_ready),
        .rsp_valid_o (bus_rsp_valid),
        .rsp_o       (bus_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // one instruction encoder per format
    function automatic logic [31:0] r_type(input int f7, input int rs2, input int rs1,
                                           input int f3, input int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input int imm, input int rs1, input int f3,
                                           input int rd, input logic [6:0] opc);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
    endfunction

    function automatic logic [31:0] s_type(input int imm, input int rs2, input int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_type(input int imm, input int rs2, input int rs1,
                                           input int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                7'b1100011};
    endfunction

    function automatic logic [31:0] j_type(input int imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    function automatic cpu_core_pkg::bus_req_t make_req(input logic [31:0] addr,
                                                       input logic write,
                                                       input logic [31:0] data);
        cpu_core_pkg::bus_req_t r;
        r.addr  = addr;
        r.write = write;
        r.wdata = data;
        return r;
    endfunction

    task automatic check_word(input string what, input logic [`CPU_XLEN-1:0] expected,
                              input logic [`CPU_XLEN-1:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("ERROR %s: %s expected %h, actual %h", cur_test, what, expected, actual);
        end
    endtask

    task automatic check_req(input string what, input cpu_core_pkg::bus_req_t expected,
                             input cpu_core_pkg::bus_req_t actual);
        if (actual !== expected) begin
            errors++;
            $display("ERROR %s: %s expected addr=%h write=%b data=%h, %s",
                     cur_test, what, expected.addr, expected.write, expected.wdata,
                     $sformatf("actual addr=%h write=%b data=%h",
                               actual.addr, actual.write, actual.wdata));
        end
    endtask

    // bus monitor for result stores and held requests
    always @(posedge clk) begin
        if (rst) begin
            held = 1'b0;
        end else begin
            if (held) begin
                if (!bus_req_valid) begin
                    errors++;
                    $display("%s: request withdrawn before the bus accepted it", cur_test);
                end
                check_req("held request", held_req, bus_req);
            end
            held = bus_req_valid && !bus_req_ready;
            if (held) begin
                held_req = bus_req;
                hold_count++;
            end
            if (bus_req_valid && bus_req_ready && bus_req.write
                    && bus_req.addr >= RESULT_BASE) begin
                stores.push_back(bus_req);
            end
        end
    end

    // load prog into memory under reset, then release
    task automatic run_program(input bit stall);
        @(posedge clk);
        #1;
        rst        = 1'b1;
        stall_en   = stall;
        hold_count = 0;
        stores.delete();
        for (int i = 0; i < 1024; i++) begin
            mem_model.mem[i] = (i < prog.size()) ? prog[i] : (32'hbad0_0000 | 32'(i * 4));
        end
        repeat (16) begin
            @(negedge clk);
            if (bus_req_valid !== 1'b0) begin
                errors++;
                $display("%s: bus request valid while reset is asserted", cur_test);
            end
        end
        @(posedge clk);
        #1;
        rst = 1'b0;
    endtask

    task automatic wait_stores(input int count, output bit ok);
        int cycles;
        cycles = 0;
        while (stores.size() < count && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        ok = (stores.size() >= count);
        if (!ok) begin
            errors++;
            $display("%s: timed out after %0d cycles waiting for %0d result stores, saw %0d",
                     cur_test, cycles, count, stores.size());
        end
    endtask

    task automatic finish_test(input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %s: ok", cur_test);
        end else begin
            tests_failed++;
            $display("test %s: failed", cur_test);
        end
    endtask

    task automatic reset_fetch_test();
        int e0;
        int cycles;
        e0       = errors;
        cur_test = "reset_fetch";
        prog.delete();
        prog.push_back(j_type(0, 0));
        run_program(1'b0);
        cycles = 0;
        while (!bus_req_valid && cycles < 100) begin
            @(negedge clk);
            cycles++;
        end
        if (!bus_req_valid) begin
            errors++;
            $display("%s: no bus request seen after reset", cur_test);
        end else begin
            check_req("first request", make_req(`CPU_RESET_PC, 1'b0, '0), bus_req);
        end
        finish_test(e0);
    endtask

    task automatic alu_ops_test(input string name, input bit stall);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] expected [14];
        int          rd_list [14];
        bit          ok;
        int          e0;
        e0       = errors;
        cur_test = name;
        a        = -291;
        b        = 1445;
        prog.delete();
        prog.push_back(i_type(256, 0, 0, 10, OPC_IMM));   // x10 = result base
        prog.push_back(i_type(-291, 0, 0, 1, OPC_IMM));
        prog.push_back(i_type(1445, 0, 0, 2, OPC_IMM));
        prog.push_back(i_type(5, 0, 0, 3, OPC_IMM));      // shift amount
        prog.push_back(r_type(0, 2, 1, 0, 4));            // add
        prog.push_back(r_type(32, 2, 1, 0, 5));           // sub
        prog.push_back(r_type(0, 2, 1, 4, 6));            // xor
        prog.push_back(r_type(0, 2, 1, 6, 7));            // or
        prog.push_back(r_type(0, 2, 1, 7, 8));            // and
        prog.push_back(r_type(0, 3, 1, 1, 9));            // sll
        prog.push_back(r_type(0, 3, 1, 5, 11));           // srl
        prog.push_back(i_type(-256, 2, 4, 12, OPC_IMM));  // xori
        prog.push_back(i_type(2032, 1, 7, 13, OPC_IMM));  // andi
        prog.push_back(i_type(3, 2, 1, 14, OPC_IMM));     // slli
        prog.push_back(i_type(28, 1, 5, 15, OPC_IMM));    // srli
        prog.push_back(i_type(112, 2, 6, 16, OPC_IMM));   // ori
        prog.push_back(i_type(-2000, 2, 0, 17, OPC_IMM)); // negative addi
        rd_list  = '{1, 4, 5, 6, 7, 8, 9, 11, 12, 13, 14, 15, 16, 17};
        expected = '{a, a + b, a - b, a ^ b, a | b, a & b, a << 5, a >> 5,
                     b ^ 32'hffff_ff00, a & 32'h7f0, b << 3, a >> 28, b | 32'h70,
                     b + 32'hffff_f830};
        foreach (rd_list[k]) begin
            prog.push_back(s_type(k * 4, rd_list[k], 10));
        end
        prog.push_back(j_type(0, 0));
        run_program(stall);
        wait_stores(14, ok);
        if (ok) begin
            foreach (expected[k]) begin
                check_req($sformatf("store %0d", k),
                          make_req(RESULT_BASE + 32'(k * 4), 1'b1, expected[k]), stores[k]);
            end
        end
        if (stall && hold_count == 0) begin
            errors++;
            $display("%s: no request was ever held by back-pressure", cur_test);
        end
        finish_test(e0);
    endtask

    task automatic load_store_test();
        logic [31:0] v;
        bit          ok;
        int          e0;
        e0       = errors;
        cur_test = "load_store";
        v        = -1365;
        v        = v << 9;
        prog.delete();
        prog.push_back(i_type(256, 0, 0, 10, OPC_IMM));
        prog.push_back(i_type(-1365, 0, 0, 1, OPC_IMM));
        prog.push_back(i_type(9, 1, 1, 1, OPC_IMM));      // slli x1, x1, 9
        prog.push_back(s_type(0, 1, 10));
        prog.push_back(i_type(0, 10, 2, 2, OPC_LOAD));    // lw x2, 0(x10)
        prog.push_back(s_type(8, 2, 10));
        prog.push_back(j_type(0, 0));
        run_program(1'b0);
        wait_stores(2, ok);
        if (ok) begin
            check_req("first store", make_req(RESULT_BASE, 1'b1, v), stores[0]);
            check_req("second store", make_req(RESULT_BASE + 32'd8, 1'b1, v), stores[1]);
            check_word("reloaded data", v, stores[1].wdata);
        end
        finish_test(e0);
    endtask

    task automatic control_flow_test();
        logic [31:0] jal_pc;
        bit          ok;
        int          e0;
        e0       = errors;
        cur_test = "control_flow";
        jal_pc   = 32'd44;  // word 11
        prog.delete();
        prog.push_back(i_type(256, 0, 0, 10, OPC_IMM));
        prog.push_back(i_type(7, 0, 0, 1, OPC_IMM));
        prog.push_back(i_type(7, 0, 0, 2, OPC_IMM));
        prog.push_back(i_type(9, 0, 0, 3, OPC_IMM));
        prog.push_back(i_type(1, 0, 0, 5, OPC_IMM));      // marker value
        prog.push_back(b_type(8, 2, 1, 0));               // beq taken
        prog.push_back(s_type(0, 5, 10));                 // skipped
        prog.push_back(b_type(8, 3, 1, 0));               // beq not taken
        prog.push_back(s_type(4, 5, 10));                 // reached
        prog.push_back(b_type(8, 3, 1, 1));               // bne taken
        prog.push_back(s_type(8, 5, 10));                 // skipped
        prog.push_back(j_type(8, 6));                     // jal x6
        prog.push_back(s_type(12, 5, 10));                // skipped
        prog.push_back(s_type(16, 6, 10));                // link value
        prog.push_back(j_type(0, 0));
        run_program(1'b0);
        wait_stores(2, ok);
        if (ok) begin
            check_req("marker store", make_req(RESULT_BASE + 32'd4, 1'b1, 32'd1), stores[0]);
            check_req("link store", make_req(RESULT_BASE + 32'd16, 1'b1, jal_pc + 32'd4),
                      stores[1]);
            check_word("link value", jal_pc + 32'd4, stores[1].wdata);
        end
        finish_test(e0);
    endtask

    task automatic zero_reg_test();
        bit ok;
        int e0;
        e0       = errors;
        cur_test = "zero_reg";
        prog.delete();
        prog.push_back(i_type(256, 0, 0, 10, OPC_IMM));
        prog.push_back(i_type(85, 0, 0, 0, OPC_IMM));     // addi x0, x0, 85
        prog.push_back(s_type(0, 0, 10));
        prog.push_back(j_type(0, 0));
        run_program(1'b0);
        wait_stores(1, ok);
        if (ok) begin
            check_req("x0 store", make_req(RESULT_BASE, 1'b1, '0), stores[0]);
        end
        finish_test(e0);
    endtask

    initial begin
        rst          = 1'b1;
        stall_en     = 1'b0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        hold_count   = 0;
        held         = 1'b0;
        cur_test     = "init";

        reset_fetch_test();
        alu_ops_test("alu_ops", 1'b0);
        load_store_test();
        control_flow_test();
        zero_reg_test();
        alu_ops_test("back_pressure", 1'b1);

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== cpu_core.f ====
+incdir+src
src/cpu_core_pkg.sv
src/instr_decoder.sv
src/alu.sv
src/register_file.sv
src/mem_controller.sv
src/core_sequencer.sv
src/cpu_core.sv
testbench/tb_memory_model.sv
testbench/tb_cpu_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_cpu_core -f cpu_core.f -o sim_cpu_core \
    && ./obj_dir/sim_cpu_core > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qxF '** PASS **' sim.log && echo "simulation passed" && exit 0 \
    || echo "simulation failed" && exit 1
